//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // word and address geometry
    localparam int XLEN        = 32;
    localparam int OFFSET_BITS = 2;
    localparam int SET_BITS    = 4;
    localparam int NUM_SETS    = 16;
    localparam int TAG_BITS    = 26;

    typedef logic [XLEN-1:0]     xlen_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [SET_BITS-1:0] set_idx_t;

    // same 32 bits seen either as a raw word or as tag/index/offset
    typedef union packed {
        xlen_t raw;
        struct packed {
            tag_t                   tag;
            set_idx_t               index;
            logic [OFFSET_BITS-1:0] offset;
        } f;
    } cache_addr_u;

    // one way of one set
    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        xlen_t data;
    } cache_line_t;

    typedef struct packed {
        logic  read;
        logic  write;
        xlen_t addr;
        xlen_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  read;
        logic  write;
        xlen_t addr;
        xlen_t wdata;
    } mem_req_t;

    // result of looking up the addressed set
    typedef struct packed {
        logic  hit;
        logic  hit_way;
        xlen_t hit_data;
        logic  victim_way;
        logic  victim_wb;
        xlen_t victim_addr;
        xlen_t victim_data;
    } lookup_t;

    typedef enum logic [1:0] {
        LINE_NONE,
        LINE_TOUCH,
        LINE_INSTALL
    } line_op_e;

    // update request from the controller to the way array
    typedef struct packed {
        line_op_e op;
        logic     way;
        tag_t     tag;
        xlen_t    data;
        logic     dirty;
    } line_cmd_t;

endpackage

`default_nettype wire

//--- design/cache_ways.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ways (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  cache_pkg::set_idx_t  set_idx_i,
    input  cache_pkg::tag_t      tag_i,
    input  cache_pkg::line_cmd_t cmd_i,
    output cache_pkg::lookup_t   lookup_o
);
    import cache_pkg::*;

    // two ways per set
    cache_line_t lines_q [NUM_SETS][2];

    // per set: index of the least recently used way
    logic [NUM_SETS-1:0] lru_q;

    cache_line_t line0;
    cache_line_t line1;
    cache_line_t victim_line;
    logic        hit0;
    logic        hit1;
    logic        victim_way;
    cache_addr_u victim_addr;

    assign line0 = lines_q[set_idx_i][0];
    assign line1 = lines_q[set_idx_i][1];

    // tag compare on both ways
    assign hit0 = line0.valid && (line0.tag == tag_i);
    assign hit1 = line1.valid && (line1.tag == tag_i);

    // an empty way is taken before the LRU way
    always_comb begin
        if (!line0.valid) begin
            victim_way = 1'b0;
        end else if (!line1.valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[set_idx_i];
        end
    end

    assign victim_line = victim_way ? line1 : line0;

    // rebuild the memory address of the line being evicted
    always_comb begin
        victim_addr.f.tag    = victim_line.tag;
        victim_addr.f.index  = set_idx_i;
        victim_addr.f.offset = '0;
    end

    always_comb begin
        lookup_o.hit         = hit0 || hit1;
        lookup_o.hit_way     = hit1;
        lookup_o.hit_data    = hit1 ? line1.data : line0.data;
        lookup_o.victim_way  = victim_way;
        // only a valid dirty line has to go back to memory
        lookup_o.victim_wb   = victim_line.valid && victim_line.dirty;
        lookup_o.victim_addr = victim_addr.raw;
        lookup_o.victim_data = victim_line.data;
    end

    // line updates, applied at the next edge
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lru_q <= '0;
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < 2; w++) begin
                    lines_q[s][w].valid <= 1'b0;
                    lines_q[s][w].dirty <= 1'b0;
                end
            end
        end else begin
            case (cmd_i.op)
                LINE_TOUCH: begin
                    // the other way becomes least recent
                    lru_q[set_idx_i] <= ~cmd_i.way;
                end
                LINE_INSTALL: begin
                    lines_q[set_idx_i][cmd_i.way] <= '{
                        valid: 1'b1,
                        dirty: cmd_i.dirty,
                        tag:   cmd_i.tag,
                        data:  cmd_i.data
                    };
                    lru_q[set_idx_i] <= ~cmd_i.way;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/cache_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cache_fsm (
    input  logic                 clk_i,
    input  logic                 rst_i,
    // processor side
    input  cache_pkg::cpu_req_t  cpu_req_i,
    output cache_pkg::xlen_t     readdata_o,
    output logic                 stb_o,
    output logic                 busy_o,
    // memory side
    output cache_pkg::mem_req_t  mem_req_o,
    input  logic                 mem_ack_i,
    input  cache_pkg::xlen_t     mem_rdata_i,
    // way array
    output cache_pkg::set_idx_t  set_idx_o,
    output cache_pkg::tag_t      tag_o,
    input  cache_pkg::lookup_t   lookup_i,
    output cache_pkg::line_cmd_t cmd_o
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITEBACK,
        S_FETCH,
        S_INSTALL,
        S_DONE
    } state_e;

    state_e      state_q;
    cpu_req_t    req_q;
    mem_req_t    mem_req_q;
    xlen_t       rdata_q;
    logic        victim_way_q;
    cache_addr_u req_addr;
    mem_req_t    fetch_req;
    mem_req_t    wb_req;

    // split the latched address into tag and set
    assign req_addr.raw = req_q.addr;
    assign set_idx_o    = req_addr.f.index;
    assign tag_o        = req_addr.f.tag;

    assign busy_o     = (state_q != S_IDLE);
    assign stb_o      = (state_q == S_DONE);
    assign readdata_o = rdata_q;
    assign mem_req_o  = mem_req_q;

    // the two memory requests the controller can issue
    always_comb begin
        fetch_req       = '0;
        fetch_req.read  = 1'b1;
        fetch_req.addr  = req_q.addr;

        wb_req          = '0;
        wb_req.write    = 1'b1;
        wb_req.addr     = lookup_i.victim_addr;
        wb_req.wdata    = lookup_i.victim_data;
    end

    // line commands to the way array
    always_comb begin
        cmd_o.op    = LINE_NONE;
        cmd_o.way   = victim_way_q;
        cmd_o.tag   = req_addr.f.tag;
        // rdata_q holds the write data or the fetched word by now
        cmd_o.data  = rdata_q;
        cmd_o.dirty = req_q.write;
        case (state_q)
            S_LOOKUP: begin
                if (lookup_i.hit) begin
                    cmd_o.way = lookup_i.hit_way;
                    if (req_q.write) begin
                        // a write hit rewrites the line in place
                        cmd_o.op    = LINE_INSTALL;
                        cmd_o.data  = req_q.wdata;
                        cmd_o.dirty = 1'b1;
                    end else begin
                        cmd_o.op = LINE_TOUCH;
                    end
                end
            end
            S_INSTALL: begin
                cmd_o.op = LINE_INSTALL;
            end
            default: begin
            end
        endcase
    end

    // state and memory request sequencing
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= S_IDLE;
            mem_req_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (cpu_req_i.read || cpu_req_i.write) begin
                        state_q <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (lookup_i.hit) begin
                        state_q <= S_DONE;
                    end else if (lookup_i.victim_wb) begin
                        mem_req_q <= wb_req;
                        state_q   <= S_WRITEBACK;
                    end else if (req_q.read) begin
                        mem_req_q <= fetch_req;
                        state_q   <= S_FETCH;
                    end else begin
                        // write miss into a clean or empty way
                        state_q <= S_INSTALL;
                    end
                end
                S_WRITEBACK: begin
                    if (mem_ack_i) begin
                        if (req_q.read) begin
                            mem_req_q <= fetch_req;
                            state_q   <= S_FETCH;
                        end else begin
                            mem_req_q <= '0;
                            state_q   <= S_INSTALL;
                        end
                    end
                end
                S_FETCH: begin
                    if (mem_ack_i) begin
                        mem_req_q <= '0;
                        state_q   <= S_INSTALL;
                    end
                end
                S_INSTALL: begin
                    state_q <= S_DONE;
                end
                S_DONE: begin
                    state_q <= S_IDLE;
                end
                default: begin
                    mem_req_q <= '0;
                    state_q   <= S_IDLE;
                end
            endcase
        end
    end

    // request, victim way and data word
    always_ff @(posedge clk_i) begin
        case (state_q)
            S_IDLE: begin
                req_q <= cpu_req_i;
            end
            S_LOOKUP: begin
                victim_way_q <= lookup_i.victim_way;
                if (req_q.read && lookup_i.hit) begin
                    rdata_q <= lookup_i.hit_data;
                end else begin
                    // read misses overwrite this with the fetched word
                    rdata_q <= req_q.wdata;
                end
            end
            S_FETCH: begin
                if (mem_ack_i) begin
                    rdata_q <= mem_rdata_i;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  logic                clk_i,
    input  logic                rst_i,
    // processor port
    input  cache_pkg::cpu_req_t cpu_req_i,
    output cache_pkg::xlen_t    readdata_o,
    output logic                stb_o,
    output logic                busy_o,
    // main memory port
    output cache_pkg::mem_req_t mem_req_o,
    input  logic                mem_ack_i,
    input  cache_pkg::xlen_t    mem_rdata_i
);
    import cache_pkg::*;

    // controller to way array
    set_idx_t  set_idx;
    tag_t      tag;
    line_cmd_t line_cmd;
    lookup_t   lookup;

    cache_fsm cache_fsm_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cpu_req_i   (cpu_req_i),
        .readdata_o  (readdata_o),
        .stb_o       (stb_o),
        .busy_o      (busy_o),
        .mem_req_o   (mem_req_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .set_idx_o   (set_idx),
        .tag_o       (tag),
        .lookup_i    (lookup),
        .cmd_o       (line_cmd)
    );

    cache_ways cache_ways_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .set_idx_i (set_idx),
        .tag_i     (tag),
        .cmd_i     (line_cmd),
        .lookup_o  (lookup)
    );

endmodule

`default_nettype wire

//--- tests/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk_o,
    output logic rst_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held over five rising edges
    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- tests/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  logic                clk_i,
    input  logic                rst_i,
    input  cache_pkg::mem_req_t mem_req_i,
    output logic                mem_ack_o,
    output cache_pkg::xlen_t    mem_rdata_o,
    output int                  read_count_o,
    output int                  write_count_o,
    output cache_pkg::mem_req_t last_write_o
);
    import cache_pkg::*;

    xlen_t    mem_q [xlen_t];
    mem_req_t wr_log [$];
    integer   seed;
    int       delay;

    initial begin
        seed          = 32'h4055;
        delay         = 0;
        mem_ack_o     = 1'b0;
        mem_rdata_o   = '0;
        read_count_o  = 0;
        write_count_o = 0;
        last_write_o  = '0;
    end

    // outputs change 1 ns after the edge
    always @(posedge clk_i) begin
        #1;
        if (rst_i || mem_ack_o) begin
            // the cache took the acknowledge at this edge
            mem_ack_o = 1'b0;
        end else if (mem_req_i.read || mem_req_i.write) begin
            // new request: 1 to 4 cycles until the acknowledge
            if (delay == 0) begin
                delay = 1 + ($unsigned($random(seed)) % 4);
            end
            delay = delay - 1;
            if (delay == 0) begin
                if (mem_req_i.write) begin
                    mem_q[mem_req_i.addr] = mem_req_i.wdata;
                    wr_log.push_back(mem_req_i);
                    last_write_o  = mem_req_i;
                    write_count_o = wr_log.size();
                end else if (mem_q.exists(mem_req_i.addr)) begin
                    mem_rdata_o  = mem_q[mem_req_i.addr];
                    read_count_o = read_count_o + 1;
                end else begin
                    // untouched words hold their address xor a fixed pattern
                    mem_rdata_o  = mem_req_i.addr ^ 32'hA5A5_0000;
                    read_count_o = read_count_o + 1;
                end
                mem_ack_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/cache_props.sv
`timescale 1ns/1ps
`default_nettype none

module cache_props (
    input logic                clk_i,
    input logic                rst_i,
    input logic                stb_o,
    input logic                busy_o,
    input cache_pkg::mem_req_t mem_req_o,
    input logic                mem_ack_i
);

    int assert_failures = 0;

    // a pending memory request holds until it is acknowledged
    mem_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_req_o.read || mem_req_o.write) && !mem_ack_i |=> $stable(mem_req_o))
        else begin
            $error("mem_req_o changed before mem_ack_i");
            assert_failures++;
        end

    // a memory request is one operation and only comes from a busy cache
    mem_rw_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_req_o.read || mem_req_o.write) |->
            busy_o && !(mem_req_o.read && mem_req_o.write))
        else begin
            $error("mem_req_o has read and write set together or is set while idle");
            assert_failures++;
        end

    // completion comes from a busy cache with memory quiet
    stb_while_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        stb_o |-> busy_o && !(mem_req_o.read || mem_req_o.write))
        else begin
            $error("stb_o high while idle or with a memory request pending");
            assert_failures++;
        end

endmodule

bind cache_top cache_props cache_props_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .stb_o     (stb_o),
    .busy_o    (busy_o),
    .mem_req_o (mem_req_o),
    .mem_ack_i (mem_ack_i)
);

`default_nettype wire

//--- tests/tb_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
    import cache_pkg::*;

    localparam logic RD = 1'b0;
    localparam logic WR = 1'b1;
    localparam logic Y  = 1'b1;
    localparam logic N  = 1'b0;
    localparam int   WAIT_LIMIT = 64;

    // one row: request, expected read data, expected fetch and write-back
    typedef struct packed {
        logic  write;
        xlen_t addr;
        xlen_t wdata;
        xlen_t rdata;
        logic  fetch;
        logic  wb;
        xlen_t wb_addr;
        xlen_t wb_data;
    } step_t;

    logic     clk_i;
    logic     rst_i;
    cpu_req_t cpu_req_i;
    xlen_t    readdata_o;
    logic     stb_o;
    logic     busy_o;
    mem_req_t mem_req_o;
    logic     mem_ack_i;
    xlen_t    mem_rdata_i;
    int       read_count;
    int       write_count;
    mem_req_t last_write;

    step_t steps [$];
    string names [$];
    // expected main memory contents
    xlen_t ref_mem [xlen_t];
    int    mismatches = 0;
    int    failures = 0;

    tb_clkgen clkgen_inst (
        .clk_o (clk_i),
        .rst_o (rst_i)
    );

    tb_mem_model mem_model_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .mem_req_i     (mem_req_o),
        .mem_ack_o     (mem_ack_i),
        .mem_rdata_o   (mem_rdata_i),
        .read_count_o  (read_count),
        .write_count_o (write_count),
        .last_write_o  (last_write)
    );

    cache_top cache_top_inst (.*);

    function automatic xlen_t mem_word(xlen_t addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return addr ^ 32'hA5A5_0000;
    endfunction

    task automatic check_word(string name, xlen_t exp, xlen_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_mem_req(string name, mem_req_t exp, mem_req_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic add_step(string name, logic write, xlen_t addr, xlen_t wdata,
                            xlen_t rdata, logic fetch, logic wb, xlen_t wb_addr,
                            xlen_t wb_data);
        names.push_back(name);
        steps.push_back(step_t'{write, addr, wdata, rdata, fetch, wb, wb_addr, wb_data});
    endtask

    task automatic wait_reset_release(output logic ok);
        ok = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !ok; i++) begin
            @(negedge clk_i);
            ok = !rst_i;
        end
    endtask

    task automatic wait_idle(output logic ok);
        ok = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !ok; i++) begin
            @(negedge clk_i);
            ok = !busy_o;
        end
    endtask

    task automatic wait_strobe(output logic ok);
        ok = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !ok; i++) begin
            @(negedge clk_i);
            ok = stb_o;
        end
    endtask

    task automatic run_step(string name, step_t s, output logic ok);
        int       reads_before;
        int       writes_before;
        int       exp_reads;
        int       exp_writes;
        mem_req_t exp_wr;
        reads_before  = read_count;
        writes_before = write_count;
        exp_reads     = s.fetch ? 1 : 0;
        exp_writes    = s.wb ? 1 : 0;
        wait_idle(ok);
        if (!ok) begin
            $display("%s: timeout, cache stayed busy before the request", name);
            failures++;
            return;
        end
        @(posedge clk_i);
        #1;
        cpu_req_i.read  = !s.write;
        cpu_req_i.write = s.write;
        cpu_req_i.addr  = s.addr;
        cpu_req_i.wdata = s.wdata;
        // accepted at this edge, so the request is withdrawn after it
        @(posedge clk_i);
        #1;
        cpu_req_i = '0;
        wait_strobe(ok);
        if (!ok) begin
            $display("%s: timeout, no completion strobe", name);
            failures++;
            return;
        end
        if (s.wb) begin
            exp_wr       = '0;
            exp_wr.write = 1'b1;
            exp_wr.addr  = s.wb_addr;
            exp_wr.wdata = s.wb_data;
            check_mem_req(name, exp_wr, last_write);
            ref_mem[s.wb_addr] = s.wb_data;
        end
        if (!s.write) begin
            check_word(name, s.rdata, readdata_o);
        end
        if (s.fetch && !s.write) begin
            check_word({name, " from memory"}, mem_word(s.addr), readdata_o);
        end
        if (read_count - reads_before != exp_reads) begin
            $display("%s: expected %0d memory reads, saw %0d", name, exp_reads,
                     read_count - reads_before);
            failures++;
        end
        if (write_count - writes_before != exp_writes) begin
            $display("%s: expected %0d memory writes, saw %0d", name, exp_writes,
                     write_count - writes_before);
            failures++;
        end
    endtask

    initial begin
        logic ok;
        int   assert_fails;
        cpu_req_i = '0;

        // set 4: fill, hit, dirty eviction and refetch
        add_step("rd_first", RD, 32'h10, 32'h0, 32'hA5A5_0010, Y, N, 32'h0, 32'h0);
        add_step("rd_repeat", RD, 32'h10, 32'h0, 32'hA5A5_0010, N, N, 32'h0, 32'h0);
        add_step("wr_hit", WR, 32'h10, 32'h1111_1111, 32'h0, N, N, 32'h0, 32'h0);
        add_step("rd_wr_hit", RD, 32'h10, 32'h0, 32'h1111_1111, N, N, 32'h0, 32'h0);
        add_step("fill_way1", RD, 32'h50, 32'h0, 32'hA5A5_0050, Y, N, 32'h0, 32'h0);
        add_step("evict_dirty", RD, 32'h90, 32'h0, 32'hA5A5_0090, Y, Y, 32'h10, 32'h1111_1111);
        add_step("rd_evicted", RD, 32'h10, 32'h0, 32'h1111_1111, Y, N, 32'h0, 32'h0);
        // set 8: LRU order A, B, touch A, then C replaces B
        add_step("lru_a", RD, 32'h20, 32'h0, 32'hA5A5_0020, Y, N, 32'h0, 32'h0);
        add_step("lru_b", RD, 32'h60, 32'h0, 32'hA5A5_0060, Y, N, 32'h0, 32'h0);
        add_step("lru_touch_a", RD, 32'h20, 32'h0, 32'hA5A5_0020, N, N, 32'h0, 32'h0);
        add_step("lru_c", RD, 32'hA0, 32'h0, 32'hA5A5_00A0, Y, N, 32'h0, 32'h0);
        add_step("lru_a_hit", RD, 32'h20, 32'h0, 32'hA5A5_0020, N, N, 32'h0, 32'h0);
        add_step("lru_b_miss", RD, 32'h60, 32'h0, 32'hA5A5_0060, Y, N, 32'h0, 32'h0);
        // set 12: write miss stays in the cache until evicted
        add_step("wr_miss", WR, 32'h30, 32'hDEAD_BEEF, 32'h0, N, N, 32'h0, 32'h0);
        add_step("rd_wr_miss", RD, 32'h30, 32'h0, 32'hDEAD_BEEF, N, N, 32'h0, 32'h0);
        add_step("fill_set12", RD, 32'h70, 32'h0, 32'hA5A5_0070, Y, N, 32'h0, 32'h0);
        add_step("evict_wr_miss", RD, 32'hB0, 32'h0, 32'hA5A5_00B0, Y, Y, 32'h30, 32'hDEAD_BEEF);

        wait_reset_release(ok);
        if (!ok) begin
            $display("timeout, reset was never released");
            failures++;
        end else begin
            if (busy_o || stb_o) begin
                $display("busy_o or stb_o is high after reset");
                failures++;
            end
            check_mem_req("reset", '0, mem_req_o);
            for (int i = 0; i < steps.size() && ok; i++) begin
                run_step(names[i], steps[i], ok);
            end
        end

        assert_fails = cache_top_inst.cache_props_inst.assert_failures;
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, failures, assert_fails);
        if (mismatches == 0 && failures == 0 && assert_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
design/cache_pkg.sv
design/cache_ways.sv
design/cache_fsm.sv
design/cache_top.sv
tests/tb_clkgen.sv
tests/tb_mem_model.sv
tests/cache_props.sv
tests/tb_cache.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_cache \
    -Mdir "$BUILD_DIR" -o sim_cache -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_cache" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
